//--- build.f
rtl/cpuPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuTop.sv
testbench/tbClock.sv
testbench/cpuTb.sv

//--- rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  wire cpuPkg::opcode_t aluOp,
  input  wire cpuPkg::word_t   a,
  input  wire cpuPkg::word_t   b,
  output cpuPkg::word_t        result
);
  import cpuPkg::*;

  logic [3:0] shamt;

  assign shamt = b[3:0];  // Only low nibble counts

  always_comb begin
    case (aluOp)
      opAdd:   result = a + b;             // Also LW/SW address
      opSub:   result = a - b;
      opAnd:   result = a & b;
      opNor:   result = ~(a | b);
      opSll:   result = a << shamt;
      opSrl:   result = a >> shamt;
      opSra:   result = word_t'($signed(a) >>> shamt);
      opLlb:   result = b;                 // Immediate straight through
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

  //////////////////////////////
  // Widths and base types
  //////////////////////////////
  localparam int wordWidth = 16;

  typedef logic [wordWidth-1:0] word_t;  // Data, instruction or address
  typedef logic [3:0]           regAddr_t;
  typedef logic [3:0]           opcode_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  localparam opcode_t opAdd = 4'd0;
  localparam opcode_t opSub = 4'd1;
  localparam opcode_t opAnd = 4'd2;
  localparam opcode_t opNor = 4'd3;
  localparam opcode_t opSll = 4'd4;
  localparam opcode_t opSrl = 4'd5;
  localparam opcode_t opSra = 4'd6;
  localparam opcode_t opLw  = 4'd8;
  localparam opcode_t opSw  = 4'd9;
  localparam opcode_t opLlb = 4'd10;
  localparam opcode_t opHlt = 4'd15;

  //////////////////////////////
  // Pipeline entries
  //////////////////////////////
  typedef struct packed {
    opcode_t aluOp;     // Operation the ALU performs
    logic    useImm;    // B operand from immediate
    logic    memRead;   // Load
    logic    memWrite;  // Store
    logic    regWrite;  // Writes rd, never set for R0
    logic    isHalt;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc;
    word_t    opA;   // Register file value of rs
    word_t    opB;   // Register file value of rt, rd for SW
    word_t    imm;   // Sign extended offset or LLB byte
    regAddr_t rs;
    regAddr_t rt;    // Second source, holds the data register on SW
    regAddr_t rd;
  } idEx_t;

  // Execute to memory
  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc;
    word_t    aluResult;  // Also the load/store address
    word_t    storeData;
    regAddr_t rd;
  } exMem_t;

  typedef struct packed {
    logic     regWrite;
    regAddr_t rd;
    word_t    data;
  } wbPort_t;

  typedef struct packed {
    word_t addr;
    word_t writeData;
    logic  read;
    logic  write;  // Strobe, write at the clock edge
  } dmemReq_t;

endpackage

`default_nettype wire

//--- rtl/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
  input  wire logic             clk,
  input  wire logic             reset,
  output cpuPkg::word_t         imemAddr,
  input  wire cpuPkg::word_t    imemData,
  output cpuPkg::dmemReq_t      dmemReq,
  input  wire cpuPkg::word_t    dmemReadData,
  output logic                  hlt,
  output cpuPkg::word_t         pc
);
  import cpuPkg::*;

  word_t   ifInstr, ifPc;
  logic    stall;
  idEx_t   idEx;
  exMem_t  exMem;
  wbPort_t wb;        // Writeback, also the late forwarding source
  logic    halting;
  word_t   haltPc;

  assign pc = imemAddr;  // Program counter doubles as the fetch address

  //////////////////////////////
  // Five stages
  //////////////////////////////
  fetchStage fetch_i (
    .clk(clk), .reset(reset), .imemData(imemData), .stall(stall),
    .halting(halting), .haltPc(haltPc), .imemAddr(imemAddr),
    .ifInstr(ifInstr), .ifPc(ifPc)
  );

  decodeStage decode_i (
    .clk(clk), .reset(reset), .ifInstr(ifInstr), .ifPc(ifPc), .wb(wb),
    .halting(halting), .stall(stall), .idEx(idEx)
  );

  executeStage execute_i (
    .clk(clk), .reset(reset), .idEx(idEx), .exMemFwd(exMem), .wb(wb),
    .halting(halting)
  );

  // Memory plus writeback register
  memoryStage memory_i (
    .clk(clk), .reset(reset), .exMem(exMem), .dmemReadData(dmemReadData),
    .dmemReq(dmemReq), .wb(wb), .halting(halting), .haltPc(haltPc), .hlt(hlt)
  );

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire cpuPkg::word_t   ifInstr,
  input  wire cpuPkg::word_t   ifPc,
  input  wire cpuPkg::wbPort_t wb,
  input  wire logic            halting,
  output logic                 stall,
  output cpuPkg::idEx_t        idEx
);
  import cpuPkg::*;

  opcode_t  opcode;
  regAddr_t rdAddr, rsAddr, rtAddr;
  regAddr_t srcB;           // rt, or rd when storing
  word_t    rsData, rtData;
  word_t    imm;
  ctrl_t    ctrl;
  logic     usesA, usesB;   // Which sources really get read

  // Instruction fields
  assign opcode = ifInstr[15:12];
  assign rdAddr = ifInstr[11:8];
  assign rsAddr = ifInstr[7:4];
  assign rtAddr = ifInstr[3:0];

  assign srcB = (opcode == opSw) ? rdAddr : rtAddr;
  assign imm  = (opcode == opLlb) ? {{8{ifInstr[7]}}, ifInstr[7:0]}
                                  : {{12{ifInstr[3]}}, ifInstr[3:0]};  // Shift amount too

  registerFile regFile_i (
    .clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(srcB),
    .rsData(rsData), .rtData(rtData), .wb(wb)
  );

  //////////////////////////////
  // Control decode
  //////////////////////////////
  always_comb begin
    ctrl  = '0;
    usesA = 1'b0;
    usesB = 1'b0;
    case (opcode)
      opAdd, opSub, opAnd, opNor: begin
        ctrl.aluOp = opcode; ctrl.regWrite = 1'b1;
        usesA = 1'b1; usesB = 1'b1;
      end
      opSll, opSrl, opSra: begin
        ctrl.aluOp = opcode; ctrl.useImm = 1'b1; ctrl.regWrite = 1'b1;
        usesA = 1'b1;
      end
      opLw: begin
        ctrl.aluOp = opAdd; ctrl.useImm = 1'b1;  // Address add
        ctrl.memRead = 1'b1; ctrl.regWrite = 1'b1;
        usesA = 1'b1;
      end
      opSw: begin
        ctrl.aluOp = opAdd; ctrl.useImm = 1'b1; ctrl.memWrite = 1'b1;
        usesA = 1'b1; usesB = 1'b1;               // Base and data
      end
      opLlb: begin
        ctrl.aluOp = opLlb; ctrl.useImm = 1'b1; ctrl.regWrite = 1'b1;
      end
      opHlt:   ctrl.isHalt = 1'b1;
      default: ctrl = '0;                         // Unused opcodes do nothing
    endcase
    if (rdAddr == '0) ctrl.regWrite = 1'b0;       // R0 stays zero
  end

  // Load-use hazard against the load now in execute
  assign stall = idEx.ctrl.memRead && (idEx.rd != '0) &&
                 ((usesA && idEx.rd == rsAddr) || (usesB && idEx.rd == srcB));

  // Decode/execute register
  always_ff @(posedge clk) begin
    if (reset || stall || halting) idEx.ctrl <= '0;  // Bubble
    else                           idEx.ctrl <= ctrl;
    idEx.pc  <= ifPc;
    idEx.opA <= rsData;
    idEx.opB <= rtData;
    idEx.imm <= imm;
    idEx.rs  <= rsAddr;
    idEx.rt  <= srcB;
    idEx.rd  <= rdAddr;
  end

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire cpuPkg::idEx_t   idEx,
  output cpuPkg::exMem_t       exMemFwd,  // Also the early forwarding source
  input  wire cpuPkg::wbPort_t wb,
  input  wire logic            halting
);
  import cpuPkg::*;

  word_t fwdA, fwdB;
  word_t aluB;
  word_t aluResult;

  //////////////////////////////
  // Forwarding
  //////////////////////////////
  // Newest producer wins, memory stage before writeback
  function automatic word_t forward(regAddr_t src, word_t regVal, exMem_t em,
                                    wbPort_t w);
    if (em.ctrl.regWrite && em.rd != '0 && em.rd == src)
      return em.aluResult;  // Never a load, stall keeps it out
    else if (w.regWrite && w.rd != '0 && w.rd == src)
      return w.data;
    else
      return regVal;
  endfunction

  assign fwdA = forward(idEx.rs, idEx.opA, exMemFwd, wb);
  assign fwdB = forward(idEx.rt, idEx.opB, exMemFwd, wb);  // Store data on SW

  assign aluB = idEx.ctrl.useImm ? idEx.imm : fwdB;

  alu alu_i (
    .aluOp(idEx.ctrl.aluOp), .a(fwdA), .b(aluB), .result(aluResult)
  );

  // Execute/memory register
  always_ff @(posedge clk) begin
    if (reset || halting) exMemFwd.ctrl <= '0;
    else                  exMemFwd.ctrl <= idEx.ctrl;
    exMemFwd.pc        <= idEx.pc;
    exMemFwd.aluResult <= aluResult;
    exMemFwd.storeData <= fwdB;
    exMemFwd.rd        <= idEx.rd;
  end

endmodule

`default_nettype wire

//--- rtl/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire cpuPkg::word_t imemData,
  input  wire logic          stall,     // Load-use hold
  input  wire logic          halting,
  input  wire cpuPkg::word_t haltPc,
  output cpuPkg::word_t      imemAddr,
  output cpuPkg::word_t      ifInstr,
  output cpuPkg::word_t      ifPc
);
  import cpuPkg::*;

  word_t pcReg;

  assign imemAddr = pcReg;  // Memory answers in the same cycle

  //////////////////////////////
  // Program counter
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (halting) begin
      pcReg <= haltPc;            // Back to HLT and stay there
    end else if (!stall) begin
      pcReg <= pcReg + word_t'(1);
    end
  end

  // Fetch/decode register
  // All-zero word decodes as ADD R0, which never writes
  always_ff @(posedge clk) begin
    if (reset || halting) begin
      ifInstr <= '0;
      ifPc    <= '0;
    end else if (!stall) begin
      ifInstr <= imemData;
      ifPc    <= pcReg;
    end
  end

endmodule

`default_nettype wire

//--- rtl/memoryStage.sv
`timescale 1ns/100ps
`default_nettype none

module memoryStage (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire cpuPkg::exMem_t exMem,
  input  wire cpuPkg::word_t  dmemReadData,
  output cpuPkg::dmemReq_t    dmemReq,
  output cpuPkg::wbPort_t     wb,
  output logic                halting,
  output cpuPkg::word_t       haltPc,
  output logic                hlt
);
  import cpuPkg::*;

  word_t wbData;
  word_t haltPcReg;  // Address of the HLT, kept once the pipe drains

  //////////////////////////////
  // Data memory request
  //////////////////////////////
  assign dmemReq.addr      = exMem.aluResult;
  assign dmemReq.writeData = exMem.storeData;
  assign dmemReq.read      = exMem.ctrl.memRead;
  assign dmemReq.write     = exMem.ctrl.memWrite;

  assign wbData = exMem.ctrl.memRead ? dmemReadData : exMem.aluResult;

  // Memory/writeback register
  always_ff @(posedge clk) begin
    if (reset || halting) wb.regWrite <= 1'b0;
    else                  wb.regWrite <= exMem.ctrl.regWrite;
    wb.rd   <= exMem.rd;
    wb.data <= wbData;
  end

  //////////////////////////////
  // Halt capture
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) hlt <= 1'b0;
    else if (exMem.ctrl.isHalt) hlt <= 1'b1;  // Sticky
  end

  always_ff @(posedge clk) begin
    if (exMem.ctrl.isHalt && !hlt) haltPcReg <= exMem.pc;
  end

  // High from HLT in this stage onward
  assign halting = exMem.ctrl.isHalt | hlt;
  assign haltPc  = hlt ? haltPcReg : exMem.pc;

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire cpuPkg::regAddr_t rsAddr,
  input  wire cpuPkg::regAddr_t rtAddr,
  output cpuPkg::word_t         rsData,
  output cpuPkg::word_t         rtData,
  input  wire cpuPkg::wbPort_t  wb
);
  import cpuPkg::*;

  word_t regs [16];

  // Read with same-cycle write bypass
  function automatic word_t readPort(regAddr_t addr, word_t stored, wbPort_t w);
    if (addr == '0)                      return '0;
    else if (w.regWrite && w.rd == addr) return w.data;
    else                                 return stored;
  endfunction

  assign rsData = readPort(rsAddr, regs[rsAddr], wb);
  assign rtData = readPort(rtAddr, regs[rtAddr], wb);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (wb.regWrite && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;  // R0 never written
    end
  end

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  logic     clk;
  logic     reset;
  word_t    imemAddr, imemData;
  word_t    dmemReadData;
  dmemReq_t dmemReq;
  logic     hlt;
  word_t    pc;

  word_t imem [256];       // Program, random words past the HLT
  word_t dmem [256];       // Low 8 address bits select the word
  word_t dmemModel [256];  // Model copy, same start contents
  word_t expAddr [$];      // Expected stores, oldest first
  word_t expData [$];
  int    storeCount;
  int    modelStores;
  int    progLen;
  word_t haltAddr;

  tbClock clock_i (.clk(clk));

  cpuTop dut_i (
    .clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
    .dmemReq(dmemReq), .dmemReadData(dmemReadData), .hlt(hlt), .pc(pc)
  );

  // Both memories answer in the same cycle
  assign imemData     = imem[imemAddr[7:0]];
  assign dmemReadData = dmemReq.read ? dmem[dmemReq.addr[7:0]] : 'x;  // Only while reading

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic failRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkEq(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  //////////////////////////////
  // Program generation
  //////////////////////////////
  function automatic word_t encode(opcode_t op, regAddr_t rd, regAddr_t rs,
                                   logic [3:0] low);
    return {op, rd, rs, low};
  endfunction

  // Mostly R0..R3 so that dependences pile up
  function automatic regAddr_t pickReg();
    if ($urandom % 4 != 0) return regAddr_t'($urandom % 4);
    return regAddr_t'($urandom % 16);
  endfunction

  task automatic buildProgram();
    int       r;
    word_t    instr;
    logic     prevLoad;
    regAddr_t prevRd;
    opcode_t  noOps [5];
    noOps    = '{4'd7, 4'd11, 4'd12, 4'd13, 4'd14};  // Undefined opcodes
    prevLoad = 1'b0;
    prevRd   = '0;
    progLen  = 20 + $urandom % 21;
    for (int i = 0; i < 256; i++) imem[i] = word_t'($urandom);
    for (int i = 0; i < 256; i++) begin
      dmem[i]      = word_t'($urandom);
      dmemModel[i] = dmem[i];
    end
    for (int i = 0; i < progLen - 1; i++) begin
      r = $urandom % 16;
      if (prevLoad && ($urandom % 2 == 1)) begin  // Load-use right behind the LW
        if ($urandom % 2 == 1) instr = encode(opSw, prevRd, pickReg(), 4'($urandom));
        else                   instr = encode(opAdd, pickReg(), prevRd, pickReg());
      end else begin
        case (r)
          0, 1, 2, 3:   instr = encode(opcode_t'(r), pickReg(), pickReg(), pickReg());
          4, 5, 6:      instr = encode(opcode_t'(r), pickReg(), pickReg(), 4'($urandom));
          7, 8, 15:     instr = encode(opLlb, pickReg(), 4'($urandom), 4'($urandom));
          9, 10:        instr = encode(opLw, pickReg(), pickReg(), 4'($urandom));
          11, 12, 13:   instr = encode(opSw, pickReg(), pickReg(), 4'($urandom));
          default:      instr = encode(noOps[$urandom % 5], pickReg(), pickReg(), pickReg());
        endcase
      end
      prevLoad = (instr[15:12] == opLw);
      prevRd   = instr[11:8];
      imem[i]  = instr;
    end
    imem[progLen-1] = encode(opHlt, '0, '0, '0);
  endtask

  //////////////////////////////
  // Instruction-set model
  //////////////////////////////
  task automatic modelProgram();
    word_t      regs [16];
    word_t      a, b, addr, result;
    opcode_t    op;
    regAddr_t   rd, rs;
    logic [3:0] low;
    logic       writes;
    expAddr.delete();
    expData.delete();
    foreach (regs[i]) regs[i] = '0;
    haltAddr = '0;
    for (int i = 0; i < progLen; i++) begin
      {op, rd, rs, low} = imem[i];
      a      = regs[rs];
      b      = regs[low];
      addr   = a + {{12{low[3]}}, low};  // Base plus signed 4-bit offset
      writes = 1'b1;
      result = '0;
      case (op)
        opAdd: result = a + b;
        opSub: result = a - b;
        opAnd: result = a & b;
        opNor: result = ~(a | b);
        opSll: result = a << low;
        opSrl: result = a >> low;
        opSra: result = word_t'($signed(a) >>> low);
        opLlb: result = {{8{rs[3]}}, rs, low};
        opLw:  result = dmemModel[addr[7:0]];
        opSw: begin
          writes = 1'b0;
          expAddr.push_back(addr);
          expData.push_back(regs[rd]);
          dmemModel[addr[7:0]] = regs[rd];
        end
        opHlt: begin
          writes   = 1'b0;
          haltAddr = word_t'(i);
        end
        default: writes = 1'b0;  // Undefined opcode, nothing happens
      endcase
      if (writes && rd != '0) regs[rd] = result;  // R0 stays zero
    end
    modelStores = expAddr.size();
  endtask

  //////////////////////////////
  // Store monitor
  //////////////////////////////
  // Request is stable at the falling edge, memory updated there
  always @(negedge clk) begin : storeMonitor
    word_t wantAddr, wantData;
    if (!reset && dmemReq.write === 1'b1) begin
      if (hlt) failRun("A store strobe came after the halt reached the memory stage");
      if (expAddr.size() == 0) failRun("The core stored more often than the model");
      wantAddr = expAddr.pop_front();
      wantData = expData.pop_front();
      checkEq("dmemReq.addr", dmemReq.addr, wantAddr);
      checkEq("dmemReq.writeData", dmemReq.writeData, wantData);
      dmem[dmemReq.addr[7:0]] = dmemReq.writeData;
      storeCount++;
    end
  end

  // One program from reset to a drained halt
  task automatic runProgram(input int index);
    int cycles;
    reset = 1'b1;
    buildProgram();
    modelProgram();
    storeCount = 0;
    for (int i = 0; i < 10; i++) begin  // Reset quiet checks
      @(negedge clk);
      checkEq("hlt", word_t'(hlt), 16'h0);
      checkEq("dmemReq.write", word_t'(dmemReq.write), 16'h0);
      checkEq("dmemReq.read", word_t'(dmemReq.read), 16'h0);
      checkEq("pc", pc, 16'h0);
    end
    reset  = 1'b0;
    cycles = 0;
    while (hlt !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 500) failRun("The core never halted within 500 cycles");
    end
    checkEq("pc", pc, haltAddr);
    for (int i = 0; i < 20; i++) begin  // Frozen at the HLT
      @(negedge clk);
      checkEq("pc", pc, haltAddr);
      checkEq("hlt", word_t'(hlt), 16'h1);
    end
    checkEq("store count", word_t'(storeCount), word_t'(modelStores));
    $display("Program %0d: %0d instructions, %0d stores, halt at 0x%h",
             index, progLen, storeCount, haltAddr);
  endtask

  initial begin
    void'($urandom(20844));
    reset = 1'b1;
    for (int n = 0; n < 5; n++) runProgram(n);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
  output logic clk
);

  // 20 ns period, first rising edge at 10 ns
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

`default_nettype wire
